/* build.f */
+incdir+dv
rtl/video_pkg.sv
rtl/pixel_if.sv
rtl/game_input_stage.sv
rtl/colour_mixer.sv
rtl/pixel_fifo.sv
rtl/vga_credit_tx.sv
rtl/popeye_video_top.sv
dv/tb_popeye_video.sv

/* Makefile */
# Verilator flow for the video path testbench
# Override any variable on the command line, e.g. make LOG=run.log

VERILATOR  ?= verilator
TOP        ?= tb_popeye_video
RTL_TOP    ?= popeye_video_top
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= All tests passed
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/video_model.svh */
`ifndef VIDEO_MODEL_SVH
`define VIDEO_MODEL_SVH

// Expected VGA words in output order, with the filter state of each
vga_word_t    exp_q[$];
logic         mix_q[$];

// Last pixel of the current line as seen by the model
game_colour_t last_r;
game_colour_t last_g;
game_colour_t last_b;
logic         model_mix;    // Filter enable at capture time

// Game difficulty code for each OSD menu entry
function automatic logic [1:0] level_code(input logic [1:0] menu);
    case (menu)
        2'd0:    return 2'b01;  // Normal
        2'd1:    return 2'b00;  // Easy
        2'd2:    return 2'b10;  // Hard
        default: return 2'b11;  // Very hard
    endcase
endfunction

function automatic vga_colour_t plain_channel(input game_colour_t c);
    return {c, c};
endfunction

// Sum of both neighbours, then its top two bits again
function automatic vga_colour_t mixed_channel(input game_colour_t cur, input game_colour_t prev);
    logic [3:0] sum;
    sum = 4'(cur) + 4'(prev);
    return {sum, sum[3:2]};
endfunction

task automatic record_pixel(
    input game_colour_t r,
    input game_colour_t g,
    input game_colour_t b,
    input logic         first
);
    game_colour_t pr;
    game_colour_t pg;
    game_colour_t pb;
    vga_word_t    w;
    pr = first ? r : last_r;    // Line start pairs with itself
    pg = first ? g : last_g;
    pb = first ? b : last_b;
    if (model_mix) begin
        w = {first, mixed_channel(r, pr), mixed_channel(g, pg), mixed_channel(b, pb)};
    end else begin
        w = {first, plain_channel(r), plain_channel(g), plain_channel(b)};
    end
    exp_q.push_back(w);
    mix_q.push_back(model_mix);
    last_r = r;
    last_g = g;
    last_b = b;
endtask

`endif

/* dv/tb_popeye_video.sv */
module tb_popeye_video import video_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_LINES      = 30;
    localparam int LINE_PIXELS    = 40;
    localparam int HB_CYCLES      = 8;
    localparam int TIMEOUT_CYCLES = NUM_LINES * 48 * 2 + 500;

    logic         clk_rgb;
    logic         reset;
    logic [31:0]  status;
    logic         pxl_cen;
    game_colour_t red;
    game_colour_t green;
    game_colour_t blue;
    logic         hb;
    logic         vb;
    logic         vga_credit;
    logic [1:0]   dip_level;
    logic [1:0]   dip_lives;
    logic         vga_valid;
    vga_colour_t  vga_r;
    vga_colour_t  vga_g;
    vga_colour_t  vga_b;
    logic         vga_sol;
    logic         overflow;

    integer      seed;
    logic [31:0] rnd;
    int          errors;
    int          words_checked;
    int          mixed_words;
    int          status_checks;
    int          outstanding;   // Words sent but not yet credited back
    int          now;
    int          last_due;
    int          check_due;
    int          credit_due[$];
    int          wdog_cycles = 0;
    logic        overflow_seen;
    logic [1:0]  exp_level;
    logic [1:0]  exp_lives;

    `include "video_model.svh"

    popeye_video_top dut0 (
        .clk_rgb    ( clk_rgb    ),
        .reset      ( reset      ),
        .status     ( status     ),
        .pxl_cen    ( pxl_cen    ),
        .red        ( red        ),
        .green      ( green      ),
        .blue       ( blue       ),
        .hb         ( hb         ),
        .vb         ( vb         ),
        .vga_credit ( vga_credit ),
        .dip_level  ( dip_level  ),
        .dip_lives  ( dip_lives  ),
        .vga_valid  ( vga_valid  ),
        .vga_r      ( vga_r      ),
        .vga_g      ( vga_g      ),
        .vga_b      ( vga_b      ),
        .vga_sol    ( vga_sol    ),
        .overflow   ( overflow   )
    );

    always #5 clk_rgb = ~clk_rgb;

    always @(posedge clk_rgb) begin
        wdog_cycles = wdog_cycles + 1;
        if (wdog_cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, %0d words never arrived", wdog_cycles,
                     exp_q.size());
            $display("Some tests failed");
            $finish;
        end
    end

    // Check outputs at one clock edge, then run the sink
    task automatic tick();
        vga_word_t   got;
        vga_word_t   want;
        int unsigned delay;
        int          due;
        @(posedge clk_rgb);
        now++;
        if (vga_valid) begin
            got = {vga_sol, vga_r, vga_g, vga_b};
            if (exp_q.size() == 0) begin
                errors++;
                $display("Error at %0t: DUT sent word %h with no captured pixel left", $time, got);
            end else begin
                want = exp_q.pop_front();
                if (mix_q.pop_front()) begin
                    mixed_words++;
                end
                if (got !== want) begin
                    errors++;
                    $display("MISMATCH at %0t: word %0d expected %b/%h/%h/%h got %b/%h/%h/%h",
                             $time, words_checked, want[18], want[17:12], want[11:6], want[5:0],
                             vga_sol, vga_r, vga_g, vga_b);
                end
                words_checked++;
            end
            outstanding++;
            delay = $unsigned($random(seed)) % 3;   // Sink latency of 0 to 2 cycles
            due = now + int'(delay);
            if (due <= last_due) begin
                due = last_due + 1;     // One credit pulse per cycle
            end
            last_due = due;
            credit_due.push_back(due);
        end
        if (outstanding > int'(INIT_CREDITS)) begin
            errors++;
            $display("Error at %0t: %0d words outstanding, more than the credits granted",
                     $time, outstanding);
        end
        if (credit_due.size() != 0 && credit_due[0] <= now) begin
            void'(credit_due.pop_front());
            outstanding--;
            vga_credit <= 1'b1;
        end else begin
            vga_credit <= 1'b0;
        end
        if (check_due == 1) begin
            status_checks++;
            if (dip_level !== exp_level || dip_lives !== exp_lives) begin
                errors++;
                $display("MISMATCH at %0t: dip_level %b dip_lives %b, expected %b and %b",
                         $time, dip_level, dip_lives, exp_level, exp_lives);
            end
        end
        if (check_due != 0) begin
            check_due--;
        end
        if (overflow === 1'b1 && !overflow_seen) begin
            overflow_seen = 1'b1;
            errors++;
            $display("Error at %0t: FIFO overflow flag went high", $time);
        end
    endtask

    task automatic pick_status();
        rnd = $random(seed);
        status    <= rnd;
        exp_level = level_code(rnd[3:2]);
        exp_lives = rnd[6:5];
        model_mix = ~rnd[9];
        check_due = 2;
    endtask

    // Active pixels on every second cycle, then horizontal blanking
    task automatic drive_line(input logic blank_v);
        int   i;
        logic first;
        first = 1'b1;
        hb <= 1'b0;
        vb <= blank_v;
        for (i = 0; i < LINE_PIXELS; i++) begin
            rnd = $random(seed);
            pxl_cen <= 1'b1;
            red     <= rnd[2:0];
            green   <= rnd[5:3];
            blue    <= rnd[8:6];
            if (!blank_v) begin
                record_pixel(rnd[2:0], rnd[5:3], rnd[8:6], first);
                first = 1'b0;
            end
            tick();
            pxl_cen <= 1'b0;
            tick();
        end
        hb <= 1'b1;
        repeat (HB_CYCLES) tick();
    endtask

    initial begin
        int line;
        seed          = 32'h5685;
        clk_rgb       = 1'b0;
        reset         = 1'b1;
        status        = '0;
        pxl_cen       = 1'b0;
        red           = '0;
        green         = '0;
        blue          = '0;
        hb            = 1'b1;
        vb            = 1'b0;
        vga_credit    = 1'b0;
        errors        = 0;
        words_checked = 0;
        mixed_words   = 0;
        status_checks = 0;
        outstanding   = 0;
        now           = 0;
        last_due      = -1;
        check_due     = 0;
        overflow_seen = 1'b0;
        repeat (5) tick();
        reset <= 1'b0;
        pick_status();      // Status decode after reset
        for (line = 0; line < NUM_LINES; line++) begin
            if (line % 6 == 4) begin
                pick_status();  // Settings only change in vertical blanking
            end
            drive_line(line % 6 >= 4);
        end
        while (exp_q.size() != 0 || outstanding != 0) begin
            tick();
        end
        repeat (20) tick();     // Catch stray words
        $display("Checked %0d words (%0d filtered, %0d plain), %0d status checks, %0d errors",
                 words_checked, mixed_words, words_checked - mixed_words, status_checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* rtl/popeye_video_top.sv */
module popeye_video_top import video_pkg::*; (
    input  logic         clk_rgb,
    input  logic         reset,
    input  logic [31:0]  status,
    input  logic         pxl_cen,
    input  game_colour_t red,
    input  game_colour_t green,
    input  game_colour_t blue,
    input  logic         hb,
    input  logic         vb,
    input  logic         vga_credit,
    output logic [1:0]   dip_level,
    output logic [1:0]   dip_lives,
    output logic         vga_valid,
    output vga_colour_t  vga_r,
    output vga_colour_t  vga_g,
    output vga_colour_t  vga_b,
    output logic         vga_sol,
    output logic         overflow
);

    pixel_if   pix_raw ();
    logic      en_mixing;
    logic      push;
    vga_word_t word;

    game_input_stage u_input (
        .clk_rgb    ( clk_rgb    ),
        .reset      ( reset      ),
        .status     ( status     ),
        .pxl_cen    ( pxl_cen    ),
        .red        ( red        ),
        .green      ( green      ),
        .blue       ( blue       ),
        .hb         ( hb         ),
        .vb         ( vb         ),
        .dip_level  ( dip_level  ),
        .dip_lives  ( dip_lives  ),
        .en_mixing  ( en_mixing  ),
        .pix        ( pix_raw    )
    );

    colour_mixer u_mixer (
        .clk_rgb    ( clk_rgb    ),
        .reset      ( reset      ),
        .en_mixing  ( en_mixing  ),
        .pix        ( pix_raw    ),
        .push       ( push       ),
        .word       ( word       )
    );

    vga_credit_tx u_tx (
        .clk_rgb    ( clk_rgb    ),
        .reset      ( reset      ),
        .push       ( push       ),
        .word       ( word       ),
        .vga_credit ( vga_credit ),
        .vga_valid  ( vga_valid  ),
        .vga_r      ( vga_r      ),
        .vga_g      ( vga_g      ),
        .vga_b      ( vga_b      ),
        .vga_sol    ( vga_sol    ),
        .overflow   ( overflow   )
    );

endmodule

/* rtl/vga_credit_tx.sv */
module vga_credit_tx import video_pkg::*; (
    input  logic        clk_rgb,
    input  logic        reset,
    input  logic        push,
    input  vga_word_t   word,
    input  logic        vga_credit,
    output logic        vga_valid,
    output vga_colour_t vga_r,
    output vga_colour_t vga_g,
    output vga_colour_t vga_b,
    output logic        vga_sol,
    output logic        overflow
);

    credit_t   credits;    // Free slots at the sink
    vga_word_t rdata;
    logic      empty;
    logic      send;

    assign send = !empty && (credits != '0);

    pixel_fifo #(
        .DEPTH      ( FIFO_DEPTH )
    ) u_fifo (
        .clk_rgb    ( clk_rgb    ),
        .reset      ( reset      ),
        .push       ( push       ),
        .wdata      ( word       ),
        .pop        ( send       ),
        .rdata      ( rdata      ),
        .empty      ( empty      ),
        .overflow   ( overflow   )
    );

    always_ff @(posedge clk_rgb) begin
        if (reset) begin
            credits <= INIT_CREDITS;
        end else begin
            case ({send, vga_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;   // Send and return cancel out
            endcase
        end
    end

    always_ff @(posedge clk_rgb) begin
        if (reset) begin
            vga_valid <= 1'b0;
        end else begin
            vga_valid <= send;
        end
    end

    always_ff @(posedge clk_rgb) begin
        if (send) begin
            {vga_sol, vga_r, vga_g, vga_b} <= rdata;
        end
    end

    // Sink must not return more credits than it was granted
    a_credit_bound: assert property (
        @(posedge clk_rgb) disable iff (reset)
        credits <= INIT_CREDITS
    );

    // Every word on the bus was covered by a credit when popped
    a_valid_has_credit: assert property (
        @(posedge clk_rgb) disable iff (reset)
        vga_valid |-> $past(credits) != '0
    );

endmodule

/* rtl/pixel_fifo.sv */
module pixel_fifo import video_pkg::*; #(
    parameter int DEPTH = FIFO_DEPTH
) (
    input  logic      clk_rgb,
    input  logic      reset,
    input  logic      push,
    input  vga_word_t wdata,
    input  logic      pop,
    output vga_word_t rdata,
    output logic      empty,
    output logic      overflow
);

    typedef logic [$clog2(DEPTH)-1:0] ptr_t;
    typedef logic [$clog2(DEPTH):0]   cnt_t;

    vga_word_t mem [DEPTH];
    ptr_t      wr_ptr;
    ptr_t      rd_ptr;
    cnt_t      count;
    logic      full;
    logic      do_write;
    logic      do_read;

    assign empty    = (count == '0);
    assign full     = (count == cnt_t'(DEPTH));
    assign do_write = push && !full;
    assign do_read  = pop && !empty;
    assign rdata    = mem[rd_ptr];     // Show-ahead read

    always_ff @(posedge clk_rgb) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (push && full) begin
                overflow <= 1'b1;  // Game can't stall, so the word is lost
            end
        end
    end

    always_ff @(posedge clk_rgb) begin
        if (do_write) begin
            mem[wr_ptr] <= wdata;
        end
    end

    // Reader must check empty before popping
    a_no_pop_empty: assert property (
        @(posedge clk_rgb) disable iff (reset)
        pop |-> !empty
    );

endmodule

/* rtl/colour_mixer.sv */
module colour_mixer import video_pkg::*; (
    input  logic      clk_rgb,
    input  logic      reset,
    input  logic      en_mixing,
    pixel_if.dst      pix,
    output logic      push,
    output vga_word_t word
);

    // Previous pixel of the current line
    game_colour_t prev_r;
    game_colour_t prev_g;
    game_colour_t prev_b;

    // Neighbour used for averaging
    game_colour_t ref_r;
    game_colour_t ref_g;
    game_colour_t ref_b;

    // Average of two 3-bit values kept as a 4-bit sum, then
    // stretched to 6 bits by repeating its top bits
    function automatic vga_colour_t expand_channel(
        input game_colour_t cur,
        input game_colour_t prev,
        input logic         avg
    );
        logic [GAME_W:0] sum;
        sum = {1'b0, cur} + {1'b0, prev};
        if (avg) begin
            return {sum, sum[GAME_W:GAME_W-1]};
        end
        return {cur, cur};
    endfunction

    // A new line never mixes with the tail of the last one
    assign ref_r = pix.sol ? pix.red   : prev_r;
    assign ref_g = pix.sol ? pix.green : prev_g;
    assign ref_b = pix.sol ? pix.blue  : prev_b;

    always_ff @(posedge clk_rgb) begin
        if (reset) begin
            push <= 1'b0;
        end else begin
            push <= pix.valid;
        end
    end

    always_ff @(posedge clk_rgb) begin
        if (pix.valid) begin
            word <= {
                pix.sol,
                expand_channel(pix.red,   ref_r, en_mixing),
                expand_channel(pix.green, ref_g, en_mixing),
                expand_channel(pix.blue,  ref_b, en_mixing)
            };
            prev_r <= pix.red;
            prev_g <= pix.green;
            prev_b <= pix.blue;
        end
    end

endmodule

/* rtl/game_input_stage.sv */
module game_input_stage import video_pkg::*; (
    input  logic         clk_rgb,
    input  logic         reset,
    input  logic [31:0]  status,
    input  logic         pxl_cen,
    input  game_colour_t red,
    input  game_colour_t green,
    input  game_colour_t blue,
    input  logic         hb,
    input  logic         vb,
    output logic [1:0]   dip_level,
    output logic [1:0]   dip_lives,
    output logic         en_mixing,
    pixel_if.src         pix
);

    logic capture;
    logic line_pending;     // Next captured pixel opens a line

    assign capture = pxl_cen && !hb && !vb;

    // OSD status decode
    always_ff @(posedge clk_rgb) begin
        if (reset) begin
            dip_level <= LEVEL_NORMAL;
            dip_lives <= 2'b00;
            en_mixing <= 1'b1;
        end else begin
            case (status[3:2])
                2'b00: dip_level <= LEVEL_NORMAL;
                2'b01: dip_level <= LEVEL_EASY;
                2'b10: dip_level <= LEVEL_HARD;
                2'b11: dip_level <= LEVEL_VHARD;
            endcase
            dip_lives <= status[6:5];
            en_mixing <= ~status[9];    // Menu bit set means filter off
        end
    end

    // Line tracking; the first line after reset counts as a new line
    always_ff @(posedge clk_rgb) begin
        if (reset) begin
            line_pending <= 1'b1;
        end else if (hb) begin
            line_pending <= 1'b1;
        end else if (capture) begin
            line_pending <= 1'b0;
        end
    end

    always_ff @(posedge clk_rgb) begin
        if (reset) begin
            pix.valid <= 1'b0;
        end else begin
            pix.valid <= capture;
        end
    end

    // Pixel payload
    always_ff @(posedge clk_rgb) begin
        if (capture) begin
            pix.red   <= red;
            pix.green <= green;
            pix.blue  <= blue;
            pix.sol   <= line_pending;
        end
    end

endmodule

/* rtl/pixel_if.sv */
interface pixel_if import video_pkg::*; ();

    logic         valid;    // One pixel per high cycle, no stall
    game_colour_t red;
    game_colour_t green;
    game_colour_t blue;
    logic         sol;      // First pixel of the line

    modport src (
        output valid,
        output red,
        output green,
        output blue,
        output sol
    );

    modport dst (
        input valid,
        input red,
        input green,
        input blue,
        input sol
    );

endinterface

/* rtl/video_pkg.sv */
package video_pkg;

    // Channel widths on each side of the colour expansion
    localparam int GAME_W   = 3;
    localparam int VGA_W    = 6;
    localparam int CREDIT_W = 3;

    typedef logic [GAME_W-1:0]   game_colour_t;
    typedef logic [VGA_W-1:0]    vga_colour_t;
    typedef logic [CREDIT_W-1:0] credit_t;

    // FIFO entry layout, MSB first: sol, red, green, blue
    typedef logic [3*VGA_W:0] vga_word_t;

    // Slots granted by the scan-out sink after reset
    localparam credit_t INIT_CREDITS = credit_t'(4);

    localparam int FIFO_DEPTH = 16;

    // Difficulty codes as the game CPU reads them. The OSD menu lists
    // Normal first, so menu order and game order differ
    localparam logic [1:0] LEVEL_NORMAL = 2'b01;
    localparam logic [1:0] LEVEL_EASY   = 2'b00;
    localparam logic [1:0] LEVEL_HARD   = 2'b10;
    localparam logic [1:0] LEVEL_VHARD  = 2'b11;

endpackage
